// File: rtl/dcache_pkg.sv
package dcache_pkg;

    //////////////////////////////
    // Geometry
    //////////////////////////////
    localparam int addr_width      = 30;
    localparam int offset_width    = 3;
    localparam int index_width     = 7;
    localparam int tag_width       = addr_width - index_width - offset_width;
    localparam int words_per_line  = 1 << offset_width;
    localparam int line_width      = 32 * words_per_line;
    // Tag and index, zero padded on the memory bus
    localparam int line_addr_width = 31;

    typedef struct packed {
        logic [tag_width-1:0]    tag;
        logic [index_width-1:0]  index;
        logic [offset_width-1:0] word_sel;
    } cache_addr_fields_t;

    // Raw word address or its tag/index/offset split
    typedef union packed {
        logic [addr_width-1:0] raw;
        cache_addr_fields_t    fields;
    } cache_addr_u;

    //////////////////////////////
    // Port bundles
    //////////////////////////////
    typedef struct packed {
        logic        write;
        cache_addr_u addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        logic                       write;
        logic [line_addr_width-1:0] line_addr;
        logic [line_width-1:0]      data;
    } mem_req_t;

    typedef struct packed {
        logic [line_width-1:0] data;
    } mem_rsp_t;

    // Controller to line storage
    typedef struct packed {
        logic               enable;
        logic               cmp;
        logic               write;
        cache_addr_fields_t addr;
        logic [31:0]        wdata;
        logic [3:0]         byte_en;
        logic               valid_in;
    } line_op_t;

    // Line storage back to controller
    typedef struct packed {
        logic                  hit;
        logic                  dirty;
        logic                  valid;
        logic [tag_width-1:0]  tag;
        logic [31:0]           rdata;
        logic [line_width-1:0] line;
    } line_status_t;

endpackage

// File: rtl/cache_word_bank.sv
module cache_word_bank (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               we,
    input  logic [3:0]                         byte_en,
    input  logic [dcache_pkg::index_width-1:0] index,
    input  logic [31:0]                        wdata,
    output logic [31:0]                        rdata
);

    localparam int depth = 1 << dcache_pkg::index_width;

    // One word of every set
    logic [31:0] mem [depth];

    // Byte lanes written independently, nothing written during reset
    always_ff @(posedge clk) begin
        if (we && !rst) begin
            for (int b = 0; b < 4; b++) begin
                if (byte_en[b]) begin
                    mem[index][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read port
    assign rdata = mem[index];

endmodule

// File: rtl/cache_meta_array.sv
module cache_meta_array #(
    parameter int width = 1
) (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               we,
    input  logic [dcache_pkg::index_width-1:0] index,
    input  logic [width-1:0]                   wdata,
    output logic [width-1:0]                   rdata
);

    localparam int depth = 1 << dcache_pkg::index_width;

    logic [width-1:0] mem [depth];

    // Whole array cleared so valid and dirty start at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[index] <= wdata;
        end
    end

    assign rdata = mem[index];

endmodule

// File: rtl/cache_line_set.sv
module cache_line_set (
    input  logic                     clk,
    input  logic                     rst,
    input  dcache_pkg::line_op_t     op,
    output dcache_pkg::line_status_t status
);

    logic [dcache_pkg::tag_width-1:0]  tag_q;
    logic                              valid_q;
    logic                              dirty_q;
    logic                              match;
    logic                              word_wr;
    logic                              fill_wr;
    logic [dcache_pkg::line_width-1:0] line_data;

    //////////////////////////////
    // Write gating
    //////////////////////////////

    // Stored tag equal and line valid
    assign match = valid_q && (op.addr.tag == tag_q);

    // Compare mode needs a match, fill mode writes regardless
    assign word_wr = op.enable && op.write && (match || !op.cmp);
    assign fill_wr = op.enable && op.write && !op.cmp;

    //////////////////////////////
    // Word banks
    //////////////////////////////
    for (genvar g = 0; g < dcache_pkg::words_per_line; g++) begin : g_bank
        localparam logic [dcache_pkg::offset_width-1:0] sel = g;

        cache_word_bank u_bank (
            .clk     (clk),
            .rst     (rst),
            .we      (word_wr && (op.addr.word_sel == sel)),
            .byte_en (op.byte_en),
            .index   (op.addr.index),
            .wdata   (op.wdata),
            .rdata   (line_data[32*g +: 32])
        );
    end

    //////////////////////////////
    // Tag, valid and dirty
    //////////////////////////////
    cache_meta_array #(.width(dcache_pkg::tag_width)) u_tag (
        .clk   (clk),
        .rst   (rst),
        .we    (fill_wr),
        .index (op.addr.index),
        .wdata (op.addr.tag),
        .rdata (tag_q)
    );

    cache_meta_array #(.width(1)) u_valid (
        .clk   (clk),
        .rst   (rst),
        .we    (fill_wr),
        .index (op.addr.index),
        .wdata (op.valid_in),
        .rdata (valid_q)
    );

    // Store hit sets dirty, fill clears it
    cache_meta_array #(.width(1)) u_dirty (
        .clk   (clk),
        .rst   (rst),
        .we    (word_wr),
        .index (op.addr.index),
        .wdata (op.cmp),
        .rdata (dirty_q)
    );

    assign status.hit   = match;
    assign status.dirty = dirty_q;
    assign status.valid = valid_q;
    assign status.tag   = tag_q;
    assign status.rdata = line_data[32*op.addr.word_sel +: 32];
    assign status.line  = line_data;

endmodule

// File: rtl/cache_controller.sv
module cache_controller (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cpu_req_valid,
    input  dcache_pkg::cpu_req_t     cpu_req,
    output logic                     cpu_req_ready,
    output logic                     cpu_rsp_valid,
    output dcache_pkg::cpu_rsp_t     cpu_rsp,
    input  logic                     cpu_rsp_ready,
    output logic                     mem_req_valid,
    output dcache_pkg::mem_req_t     mem_req,
    input  logic                     mem_req_ready,
    input  logic                     mem_rsp_valid,
    input  dcache_pkg::mem_rsp_t     mem_rsp,
    output logic                     mem_rsp_ready,
    output dcache_pkg::line_op_t     line_op,
    input  dcache_pkg::line_status_t line_status
);

    typedef enum logic [2:0] {
        idle, lookup, write_back, refill_req, refill_wait, fill, respond
    } state_t;

    state_t                              state;
    dcache_pkg::cpu_req_t                req_q;
    dcache_pkg::cpu_rsp_t                rsp_q;
    logic [dcache_pkg::line_width-1:0]   refill_q;
    logic [dcache_pkg::offset_width-1:0] fill_cnt;
    logic [31:0]                         merged;
    dcache_pkg::cache_addr_u             victim_addr;

    // Store data laid over the stored word
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = req_q.byte_en[b] ? req_q.wdata[8*b +: 8]
                                                : line_status.rdata[8*b +: 8];
        end
    end

    //////////////////////////////
    // FSM
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            fill_cnt <= '0;
        end else begin
            case (state)
                idle: begin
                    if (cpu_req_valid) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (line_status.hit) begin
                        state <= respond;
                    end else if (line_status.valid && line_status.dirty) begin
                        state <= write_back;
                    end else begin
                        state <= refill_req;
                    end
                end
                write_back: begin
                    if (mem_req_ready) begin
                        state <= refill_req;
                    end
                end
                refill_req: begin
                    if (mem_req_ready) begin
                        state <= refill_wait;
                    end
                end
                refill_wait: begin
                    if (mem_rsp_valid) begin
                        state <= fill;
                    end
                end
                fill: begin
                    // Counter wraps back to 0 after the last word
                    fill_cnt <= fill_cnt + 1'b1;
                    if (&fill_cnt) begin
                        state <= lookup;
                    end
                end
                respond: begin
                    if (cpu_rsp_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && cpu_req_valid) begin
            req_q <= cpu_req;
        end
        // Stores answer with the merged word
        if (state == lookup && line_status.hit) begin
            rsp_q.rdata <= req_q.write ? merged : line_status.rdata;
        end
        if (state == refill_wait && mem_rsp_valid) begin
            refill_q <= mem_rsp.data;
        end
    end

    assign cpu_req_ready = (state == idle);
    assign cpu_rsp_valid = (state == respond);
    assign cpu_rsp       = rsp_q;
    assign mem_req_valid = (state == write_back) || (state == refill_req);
    assign mem_rsp_ready = (state == refill_wait);

    //////////////////////////////
    // Memory request
    //////////////////////////////
    always_comb begin
        victim_addr.fields.tag      = line_status.tag;
        victim_addr.fields.index    = req_q.addr.fields.index;
        victim_addr.fields.word_sel = '0;
        mem_req.write = (state == write_back);
        if (state == write_back) begin
            mem_req.line_addr = dcache_pkg::line_addr_width'(
                victim_addr.raw[dcache_pkg::addr_width-1:dcache_pkg::offset_width]);
            mem_req.data      = line_status.line;
        end else begin
            mem_req.line_addr = dcache_pkg::line_addr_width'(
                req_q.addr.raw[dcache_pkg::addr_width-1:dcache_pkg::offset_width]);
            mem_req.data      = '0;
        end
    end

    // Lookup compares against the request, fill streams the refill line
    always_comb begin
        line_op.enable   = (state == lookup) || (state == fill);
        line_op.cmp      = (state != fill);
        line_op.write    = (state == fill) || req_q.write;
        line_op.addr     = req_q.addr.fields;
        line_op.wdata    = req_q.wdata;
        line_op.byte_en  = req_q.byte_en;
        line_op.valid_in = 1'b1;
        if (state == fill) begin
            line_op.addr.word_sel = fill_cnt;
            line_op.wdata         = refill_q[32*fill_cnt +: 32];
            line_op.byte_en       = 4'hf;
        end
    end

endmodule

// File: rtl/dcache_top.sv
module dcache_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_req_valid,
    input  dcache_pkg::cpu_req_t cpu_req,
    output logic                 cpu_req_ready,
    output logic                 cpu_rsp_valid,
    output dcache_pkg::cpu_rsp_t cpu_rsp,
    input  logic                 cpu_rsp_ready,
    output logic                 mem_req_valid,
    output dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_req_ready,
    input  logic                 mem_rsp_valid,
    input  dcache_pkg::mem_rsp_t mem_rsp,
    output logic                 mem_rsp_ready
);

    dcache_pkg::line_op_t     line_op;
    dcache_pkg::line_status_t line_status;

    cache_controller u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp       (cpu_rsp),
        .cpu_rsp_ready (cpu_rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready),
        .line_op       (line_op),
        .line_status   (line_status)
    );

    // Single way, 128 sets of 8 words
    cache_line_set u_lines (
        .clk    (clk),
        .rst    (rst),
        .op     (line_op),
        .status (line_status)
    );

endmodule

// File: tests/dcache_properties.sv
module dcache_properties (
    input logic                 clk,
    input logic                 rst,
    input logic                 cpu_req_valid,
    input logic                 cpu_req_ready,
    input logic                 cpu_rsp_valid,
    input dcache_pkg::cpu_rsp_t cpu_rsp,
    input logic                 cpu_rsp_ready,
    input logic                 mem_req_valid,
    input dcache_pkg::mem_req_t mem_req,
    input logic                 mem_req_ready,
    input logic                 mem_rsp_ready
);

    int   failures = 0;
    logic busy;

    // Set from acceptance until the response is taken
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (cpu_req_valid && cpu_req_ready) begin
            busy <= 1'b1;
        end else if (cpu_rsp_valid && cpu_rsp_ready) begin
            busy <= 1'b0;
        end
    end

    //////////////////////////////
    // Handshakes
    //////////////////////////////

    // Response held until the CPU takes it
    rsp_held: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_valid && !cpu_rsp_ready |=> cpu_rsp_valid && $stable(cpu_rsp))
    else begin
        failures++;
        $error("cpu_rsp dropped or changed while stalled");
    end

    mem_req_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
    else begin
        failures++;
        $error("mem_req dropped or changed while stalled");
    end

    // Only one request in flight
    no_accept_in_flight: assert property (@(posedge clk) disable iff (rst)
        busy |-> !cpu_req_ready)
    else begin
        failures++;
        $error("cpu_req_ready high while a request is still in flight");
    end

    no_rsp_without_req: assert property (@(posedge clk) disable iff (rst)
        cpu_rsp_valid |-> busy)
    else begin
        failures++;
        $error("cpu_rsp_valid high with no request in flight");
    end

    //////////////////////////////
    // Reset state
    //////////////////////////////
    reset_outputs: assert property (@(posedge clk)
        rst |=> cpu_req_ready && !cpu_rsp_valid && !mem_req_valid && !mem_rsp_ready)
    else begin
        failures++;
        $error("control outputs not at their reset values after rst");
    end

endmodule

// File: tests/dcache_checker.sv
module dcache_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_req_valid,
    input  dcache_pkg::cpu_req_t cpu_req,
    input  logic                 cpu_req_ready,
    input  logic                 cpu_rsp_valid,
    input  dcache_pkg::cpu_rsp_t cpu_rsp,
    input  logic                 cpu_rsp_ready,
    input  logic                 mem_req_valid,
    input  dcache_pkg::mem_req_t mem_req,
    input  logic                 mem_req_ready,
    input  int                   exp_wb,
    input  int                   exp_rd,
    output int                   checks,
    output int                   errors
);

    // Sparse word image of memory as the CPU sees it
    logic [31:0] image [int];
    // Line held by each set, by index
    logic [26:0] resident [int];
    logic [29:0] req_addr;
    logic [31:0] exp_rdata;
    int          set_idx;
    int          wb_seen;
    int          rd_seen;

    // Untouched words hold their address xor a fixed pattern
    function automatic logic [31:0] image_word(input logic [29:0] addr);
        if (image.exists(int'(addr))) begin
            return image[int'(addr)];
        end
        return {2'b00, addr} ^ 32'hA5A5_0000;
    endfunction

    function automatic logic [255:0] image_line(input logic [26:0] line_addr);
        logic [255:0] line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = image_word({line_addr, w[2:0]});
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            checks  = 0;
            errors  = 0;
            wb_seen = 0;
            rd_seen = 0;
            resident.delete();
        end else begin
            // Accepted request, stores merged into the image right away
            if (cpu_req_valid && cpu_req_ready) begin
                req_addr  = cpu_req.addr.raw;
                exp_rdata = image_word(req_addr);
                if (cpu_req.write) begin
                    for (int b = 0; b < 4; b++) begin
                        if (cpu_req.byte_en[b]) begin
                            exp_rdata[8*b +: 8] = cpu_req.wdata[8*b +: 8];
                        end
                    end
                    image[int'(req_addr)] = exp_rdata;
                end
                wb_seen = 0;
                rd_seen = 0;
            end

            //////////////////////////////
            // Memory traffic
            //////////////////////////////
            if (mem_req_valid && mem_req_ready) begin
                set_idx = int'(req_addr[9:3]);
                if (mem_req.write) begin
                    wb_seen++;
                    if (!resident.exists(set_idx)) begin
                        $display("Write-back issued for a set that holds no line");
                        errors++;
                    end else begin
                        if (mem_req.line_addr !== 31'(resident[set_idx])) begin
                            $display("[FAIL] mem_req.line_addr exp=%h got=%h",
                                     31'(resident[set_idx]), mem_req.line_addr);
                            errors++;
                        end
                        if (mem_req.data !== image_line(resident[set_idx])) begin
                            $display("[FAIL] mem_req.data exp=%h got=%h",
                                     image_line(resident[set_idx]), mem_req.data);
                            errors++;
                        end
                    end
                end else begin
                    rd_seen++;
                    if (mem_req.line_addr !== 31'(req_addr[29:3])) begin
                        $display("[FAIL] mem_req.line_addr exp=%h got=%h",
                                 31'(req_addr[29:3]), mem_req.line_addr);
                        errors++;
                    end
                    // The refilled line takes over the set
                    resident[set_idx] = req_addr[29:3];
                end
            end

            // Response taken by the CPU
            if (cpu_rsp_valid && cpu_rsp_ready) begin
                checks++;
                if (cpu_rsp.rdata !== exp_rdata) begin
                    $display("[FAIL] cpu_rsp.rdata exp=%h got=%h", exp_rdata, cpu_rsp.rdata);
                    errors++;
                end
                if (wb_seen != exp_wb) begin
                    $display("Wrong number of line write-backs: expected %0d, saw %0d",
                             exp_wb, wb_seen);
                    errors++;
                end
                if (rd_seen != exp_rd) begin
                    $display("Wrong number of line reads: expected %0d, saw %0d",
                             exp_rd, rd_seen);
                    errors++;
                end
            end
        end
    end

endmodule

// File: tests/dcache_tb.sv
module dcache_tb;

    localparam int timeout_cycles = 150;

    // One table row, expected line write-backs and line reads included
    typedef struct packed {
        logic        write;
        logic [29:0] addr;
        logic [31:0] wdata;
        logic [3:0]  byte_en;
        logic [1:0]  exp_wb;
        logic [1:0]  exp_rd;
    } stim_t;

    logic                 clk;
    logic                 rst;
    logic                 cpu_req_valid;
    dcache_pkg::cpu_req_t cpu_req;
    logic                 cpu_req_ready;
    logic                 cpu_rsp_valid;
    dcache_pkg::cpu_rsp_t cpu_rsp;
    logic                 cpu_rsp_ready;
    logic                 mem_req_valid;
    dcache_pkg::mem_req_t mem_req;
    logic                 mem_req_ready;
    logic                 mem_rsp_valid;
    dcache_pkg::mem_rsp_t mem_rsp;
    logic                 mem_rsp_ready;

    int                   exp_wb;
    int                   exp_rd;
    int                   checks;
    int                   errors;
    bit                   timed_out;
    stim_t                stim_q [$];
    string                label_q [$];

    // Memory model state
    logic [255:0]         line_store [int];
    logic                 in_reset;
    logic                 rd_pending;
    int                   rd_delay;
    int                   rd_line;
    logic                 rsp_done;

    always #10 clk = ~clk;

    dcache_top UUT (.*);

    dcache_checker u_checker (.*);

    bind cache_controller dcache_properties u_props (
        .clk           (clk),
        .rst           (rst),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_ready (cpu_req_ready),
        .cpu_rsp_valid (cpu_rsp_valid),
        .cpu_rsp       (cpu_rsp),
        .cpu_rsp_ready (cpu_rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_ready (mem_rsp_ready)
    );

    //////////////////////////////
    // Memory model
    //////////////////////////////
    function automatic logic [255:0] load_line(input int line_addr);
        logic [255:0] line;
        logic [29:0]  word_addr;
        if (line_store.exists(line_addr)) begin
            return line_store[line_addr];
        end
        for (int w = 0; w < 8; w++) begin
            word_addr        = {line_addr[26:0], w[2:0]};
            line[32*w +: 32] = {2'b00, word_addr} ^ 32'hA5A5_0000;
        end
        return line;
    endfunction

    // Transfers taken at the rising edge
    always @(posedge clk) begin
        in_reset = rst;
        if (!rst && mem_req_valid && mem_req_ready) begin
            if (mem_req.write) begin
                line_store[int'(mem_req.line_addr)] = mem_req.data;
            end else begin
                rd_pending = 1'b1;
                rd_line    = int'(mem_req.line_addr);
                rd_delay   = $urandom % 6;
            end
        end
        if (!rst && mem_rsp_valid && mem_rsp_ready) begin
            rsp_done = 1'b1;
        end
    end

    // Random stalls and delayed read data
    always @(negedge clk) begin
        if (!in_reset) begin
            if (rsp_done) begin
                mem_rsp_valid = 1'b0;
                rsp_done      = 1'b0;
            end
            if (rd_pending) begin
                if (rd_delay == 0) begin
                    mem_rsp.data  = load_line(rd_line);
                    mem_rsp_valid = 1'b1;
                    rd_pending    = 1'b0;
                end else begin
                    rd_delay--;
                end
            end
            mem_req_ready = ($urandom % 4) != 0;
            cpu_rsp_ready = ($urandom % 3) != 0;
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    task automatic add_entry(input logic write, input logic [29:0] addr,
                             input logic [31:0] wdata, input logic [3:0] byte_en,
                             input int wb, input int rd, input string label);
        stim_t s;
        s = '{write, addr, wdata, byte_en, wb[1:0], rd[1:0]};
        stim_q.push_back(s);
        label_q.push_back(label);
    endtask

    task automatic wait_accept(output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < timeout_cycles) begin
            @(posedge clk);
            ok = cpu_req_ready;
            n++;
        end
    endtask

    task automatic wait_response(output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < timeout_cycles) begin
            @(posedge clk);
            ok = cpu_rsp_valid && cpu_rsp_ready;
            n++;
        end
    endtask

    initial begin
        bit ok;
        int err_before;
        void'($urandom(61));
        clk           = 1'b0;
        rst           = 1'b1;
        cpu_req_valid = 1'b0;
        cpu_req       = '0;
        cpu_rsp_ready = 1'b0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        in_reset      = 1'b1;
        rd_pending    = 1'b0;
        rd_delay      = 0;
        rd_line       = 0;
        rsp_done      = 1'b0;
        exp_wb        = 0;
        exp_rd        = 0;
        timed_out     = 1'b0;

        // Index 2 holds lines 0x010 and 0x410, index 4 lines 0x020 and 0x420
        add_entry(0, 30'h0000010, 32'h0, 4'h0, 0, 1, "cold read miss");
        add_entry(1, 30'h0000012, 32'h1122_3344, 4'h3, 0, 0, "partial write hit");
        add_entry(0, 30'h0000012, 32'h0, 4'h0, 0, 0, "read merged word");
        add_entry(0, 30'h0000017, 32'h0, 4'h0, 0, 0, "read other word of line");
        add_entry(0, 30'h0000410, 32'h0, 4'h0, 1, 1, "evict dirty line");
        add_entry(0, 30'h0000012, 32'h0, 4'h0, 0, 1, "re-read evicted word");
        add_entry(0, 30'h0000414, 32'h0, 4'h0, 0, 1, "evict clean line");
        add_entry(1, 30'h0000020, 32'hDEAD_BEEF, 4'hf, 0, 1, "write miss allocates");
        add_entry(1, 30'h0000425, 32'h7700_0000, 4'h8, 1, 1, "write miss evicts dirty");
        add_entry(0, 30'h0000020, 32'h0, 4'h0, 1, 1, "read back written word");
        add_entry(0, 30'h3FFF_FFFF, 32'h0, 4'h0, 0, 1, "read top of memory");
        add_entry(1, 30'h3FFF_FFFE, 32'h0055_0000, 4'h4, 0, 0, "byte write in last set");
        add_entry(0, 30'h00003F8, 32'h0, 4'h0, 1, 1, "evict last set");
        add_entry(0, 30'h0000021, 32'h0, 4'h0, 0, 0, "hit after refill");

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < stim_q.size() && !timed_out; i++) begin
            err_before       = errors;
            cpu_req.write    = stim_q[i].write;
            cpu_req.addr.raw = stim_q[i].addr;
            cpu_req.wdata    = stim_q[i].wdata;
            cpu_req.byte_en  = stim_q[i].byte_en;
            exp_wb           = stim_q[i].exp_wb;
            exp_rd           = stim_q[i].exp_rd;
            cpu_req_valid    = 1'b1;
            wait_accept(ok);
            if (!ok) begin
                $display("Timeout: test %0d (%s) was never accepted", i, label_q[i]);
                timed_out = 1'b1;
            end else begin
                @(negedge clk);
                cpu_req_valid = 1'b0;
                wait_response(ok);
                if (!ok) begin
                    $display("Timeout: no response for test %0d (%s)", i, label_q[i]);
                    timed_out = 1'b1;
                end else begin
                    @(negedge clk);
                    $display("test %0d  %s  %s", i, label_q[i],
                             errors == err_before ? "ok" : "error");
                end
            end
        end

        $display("tests %0d  checks %0d  errors %0d  assertion failures %0d",
                 stim_q.size(), checks, errors, UUT.u_ctrl.u_props.failures);
        if (errors == 0 && !timed_out && UUT.u_ctrl.u_props.failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: dcache_top.f
rtl/dcache_pkg.sv
rtl/cache_word_bank.sv
rtl/cache_meta_array.sv
rtl/cache_line_set.sv
rtl/cache_controller.sv
rtl/dcache_top.sv
tests/dcache_properties.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

// File: Bender.yml
package:
  name: dcache

sources:
  # Design, in compile order
  - rtl/dcache_pkg.sv
  - rtl/cache_word_bank.sv
  - rtl/cache_meta_array.sv
  - rtl/cache_line_set.sv
  - rtl/cache_controller.sv
  - rtl/dcache_top.sv

  # Testbench
  - target: test
    files:
      - tests/dcache_properties.sv
      - tests/dcache_checker.sv
      - tests/dcache_tb.sv
